/* store_cache_top.f */
+incdir+include
design/cache_addr_pkg.sv
design/store_op_pkg.sv
design/cache_port_if.sv
design/store_cache_ctrl.sv
design/cache_bank.sv
design/bank_hit_merge.sv
design/store_write_buffer.sv
design/store_cache_top.sv
verif/tb_clock_gen.sv
verif/tb_store_cache.sv

/* verif/tb_store_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module tb_store_cache;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int ENTRIES        = 1 << `INDEX_BITS;

    logic                             clk;
    logic                             rst_n;
    logic                             req;
    store_op_pkg::req_kind_t          req_kind;
    cache_addr_pkg::data_cache_addr_t req_addr;
    logic [`PORT_WIDTH-1:0]           req_data;
    store_op_pkg::mem_op_width_t      req_width;
    logic                             done;
    logic                             idle;
    logic                             probe_hit;
    logic [`PORT_WIDTH-1:0]           probe_data;
    logic                             probe_dirty;
    logic                             mem_ready;
    logic                             mem_write;
    logic [31:0]                      mem_addr;
    logic [`PORT_WIDTH-1:0]           mem_data;
    logic [`PORT_BYTES-1:0]           mem_strb;

    // reference copy of every bank
    logic                   ref_valid [`NUM_BANKS][ENTRIES];
    logic                   ref_dirty [`NUM_BANKS][ENTRIES];
    logic [`TAG_BITS-1:0]   ref_tag   [`NUM_BANKS][ENTRIES];
    logic [`PORT_WIDTH-1:0] ref_data  [`NUM_BANKS][ENTRIES];

    store_op_pkg::wbuf_entry_t exp_q [$];

    logic [31:0]            rng;
    int                     checks;
    int                     value_errors;
    int                     other_errors;
    int                     exp_lat;
    logic                   exp_hit;
    logic                   exp_dirty;
    logic [`PORT_WIDTH-1:0] exp_data;
    logic                   probe_req;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    store_cache_top dut0 (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .req_i         (req),
        .req_kind_i    (req_kind),
        .req_addr_i    (req_addr),
        .req_data_i    (req_data),
        .req_width_i   (req_width),
        .done_o        (done),
        .idle_o        (idle),
        .probe_hit_o   (probe_hit),
        .probe_data_o  (probe_data),
        .probe_dirty_o (probe_dirty),
        .mem_ready_i   (mem_ready),
        .mem_write_o   (mem_write),
        .mem_addr_o    (mem_addr),
        .mem_data_o    (mem_data),
        .mem_strb_o    (mem_strb)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected lane data in the upper 32 bits, byte strobe in the low 4
    function automatic logic [35:0] lane_align(
        input store_op_pkg::mem_op_width_t width,
        input logic [1:0]                  byte_sel,
        input logic [31:0]                 data
    );
        logic [31:0] d;
        logic [3:0]  s;
        int          lane;
        case (width)
            store_op_pkg::BYTE: begin
                lane = byte_sel;
                s    = 4'b0001 << lane;
                d    = {24'h0, data[7:0]} << (8 * lane);
            end
            store_op_pkg::HALF_WORD: begin
                lane = byte_sel[1] ? 2 : 0;
                s    = 4'b0011 << lane;
                d    = {16'h0, data[15:0]} << (8 * lane);
            end
            default: begin
                s = 4'hf;
                d = data;
            end
        endcase
        return {d, s};
    endfunction

    function automatic cache_addr_pkg::data_cache_addr_t make_addr(
        input logic [22:0] tag,
        input logic [4:0]  index,
        input logic [1:0]  chip_sel,
        input logic [1:0]  byte_sel
    );
        cache_addr_pkg::data_cache_addr_t a;
        a.tag      = tag;
        a.index    = index;
        a.chip_sel = chip_sel;
        a.byte_sel = byte_sel;
        return a;
    endfunction

    // four tags and four indexes per bank, so random requests hit often
    function automatic cache_addr_pkg::data_cache_addr_t rand_addr(input logic [31:0] r);
        return make_addr({21'h0f0f0, r[1:0]}, {3'b000, r[3:2]}, r[5:4], r[7:6]);
    endfunction

    task automatic compare_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("Fail %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
    endtask

    task automatic abort_run(input string why);
        other_errors++;
        $display("%s at %0t", why, $time);
        report_counts();
        $display("Finished with errors");
        $finish;
    endtask

    // updates the model, then presents the request one step after the clock edge
    task automatic start_req(
        input store_op_pkg::req_kind_t          kind,
        input cache_addr_pkg::data_cache_addr_t addr,
        input logic [31:0]                      data,
        input store_op_pkg::mem_op_width_t      width
    );
        logic [35:0]               lanes;
        logic                      hit;
        int                        cs;
        int                        ix;
        store_op_pkg::wbuf_entry_t ent;
        @(posedge clk);
        #1;
        cs        = addr.chip_sel;
        ix        = addr.index;
        hit       = ref_valid[cs][ix] && (ref_tag[cs][ix] == addr.tag);
        lanes     = lane_align(width, addr.byte_sel, data);
        exp_hit   = hit;
        exp_data  = ref_data[cs][ix];
        exp_dirty = ref_dirty[cs][ix];
        probe_req = (kind == store_op_pkg::PROBE);
        case (kind)
            store_op_pkg::STORE: begin
                if (hit) begin
                    exp_lat = 2;
                    for (int b = 0; b < `PORT_BYTES; b++) begin
                        if (lanes[b]) ref_data[cs][ix][8*b +: 8] = lanes[4 + 8*b +: 8];
                    end
                    ref_dirty[cs][ix] = 1'b1;
                end else begin
                    // a full buffer with memory stalled gives no fixed latency
                    exp_lat  = (exp_q.size() >= `WBUF_DEPTH && !mem_ready) ? 0 : 2;
                    ent.addr = {addr[31:`BYTE_SEL_BITS], 2'b00};
                    ent.data = lanes[35:4];
                    ent.strb = lanes[3:0];
                    exp_q.push_back(ent);
                end
            end
            store_op_pkg::INVALIDATE: begin
                exp_lat = hit ? 2 : 1;
                if (hit) ref_valid[cs][ix] = 1'b0;
            end
            store_op_pkg::FILL: begin
                exp_lat           = 1;
                ref_valid[cs][ix] = 1'b1;
                ref_dirty[cs][ix] = 1'b0;
                ref_tag[cs][ix]   = addr.tag;
                ref_data[cs][ix]  = data;
            end
            default: begin
                exp_lat = 1;
            end
        endcase
        req       = 1'b1;
        req_kind  = kind;
        req_addr  = addr;
        req_data  = data;
        req_width = width;
    endtask

    task automatic finish_req();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYCLES) abort_run("no done_o for a request within the timeout");
        end while (!done);
        // the first falling edge is still before the sampling edge
        if (exp_lat != 0) begin
            checks++;
            if (n - 1 != exp_lat) begin
                other_errors++;
                $display("done_o came %0d cycles after the request was taken instead of %0d",
                         n - 1, exp_lat);
            end
        end
        if (probe_req) begin
            compare_value("probe_hit_o", exp_hit, probe_hit);
            if (exp_hit) begin
                compare_value("probe_data_o", exp_data, probe_data);
                compare_value("probe_dirty_o", exp_dirty, probe_dirty);
            end
        end
        // drop the request after the done edge so an idle controller does not take it again
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    task automatic drain_writes();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYCLES) abort_run("expected memory writes did not all appear");
        end
    endtask

    // every memory transfer must match the oldest outstanding store miss
    always @(negedge clk) begin
        if (rst_n && mem_write) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("memory write to %h with no store miss outstanding", mem_addr);
            end else begin
                compare_value("mem_addr_o", exp_q[0].addr, mem_addr);
                compare_value("mem_data_o", exp_q[0].data, mem_data);
                compare_value("mem_strb_o", exp_q[0].strb, mem_strb);
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        cache_addr_pkg::data_cache_addr_t a;
        cache_addr_pkg::data_cache_addr_t b;
        logic [31:0]                      r;
        int                               n;
        req          = 1'b0;
        req_kind     = store_op_pkg::STORE;
        req_addr     = '0;
        req_data     = '0;
        req_width    = store_op_pkg::WORD;
        mem_ready    = 1'b1;
        rng          = 32'h32889dd4;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        for (int bk = 0; bk < `NUM_BANKS; bk++) begin
            for (int e = 0; e < ENTRIES; e++) begin
                ref_valid[bk][e] = 1'b0;
                ref_dirty[bk][e] = 1'b0;
            end
        end
        n = 0;
        while (!rst_n) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT_CYCLES) abort_run("reset was never released");
        end

        // after reset nothing is cached and nothing moves
        @(negedge clk);
        compare_value("idle_o", 1, idle);
        compare_value("mem_write_o", 0, mem_write);
        compare_value("done_o", 0, done);
        repeat (4) begin
            rng = xorshift32(rng);
            start_req(store_op_pkg::PROBE, rand_addr(rng), 32'h0, store_op_pkg::WORD);
            finish_req();
        end

        // fill, then hit on probe with clean data
        a = make_addr(23'h0f0f1, 5'd3, 2'd2, 2'd0);
        start_req(store_op_pkg::FILL, a, 32'hcafe_1234, store_op_pkg::WORD);
        finish_req();
        start_req(store_op_pkg::PROBE, a, 32'h0, store_op_pkg::WORD);
        finish_req();

        // partial stores on a hit merge into their lanes only
        a.byte_sel = 2'd3;
        start_req(store_op_pkg::STORE, a, 32'h0000_00a5, store_op_pkg::BYTE);
        finish_req();
        a.byte_sel = 2'd0;
        start_req(store_op_pkg::STORE, a, 32'h1234_5678, store_op_pkg::HALF_WORD);
        finish_req();
        start_req(store_op_pkg::PROBE, a, 32'h0, store_op_pkg::WORD);
        finish_req();
        b = make_addr(23'h0f0f3, 5'd1, 2'd1, 2'd0);
        start_req(store_op_pkg::FILL, b, 32'h0bad_f00d, store_op_pkg::WORD);
        finish_req();
        start_req(store_op_pkg::STORE, b, 32'h5566_7788, store_op_pkg::WORD);
        finish_req();
        start_req(store_op_pkg::PROBE, b, 32'h0, store_op_pkg::WORD);
        finish_req();
        drain_writes();

        // store miss on an occupied entry goes to memory only
        b = make_addr(23'h0f0f2, 5'd3, 2'd2, 2'd2);
        start_req(store_op_pkg::STORE, b, 32'h0000_beef, store_op_pkg::HALF_WORD);
        finish_req();
        drain_writes();
        start_req(store_op_pkg::PROBE, a, 32'h0, store_op_pkg::WORD);
        finish_req();
        start_req(store_op_pkg::PROBE, b, 32'h0, store_op_pkg::WORD);
        finish_req();

        // invalidate miss leaves the entry, invalidate hit clears it
        start_req(store_op_pkg::INVALIDATE, b, 32'h0, store_op_pkg::WORD);
        finish_req();
        start_req(store_op_pkg::PROBE, a, 32'h0, store_op_pkg::WORD);
        finish_req();
        start_req(store_op_pkg::INVALIDATE, a, 32'h0, store_op_pkg::WORD);
        finish_req();
        start_req(store_op_pkg::PROBE, a, 32'h0, store_op_pkg::WORD);
        finish_req();

        // with memory stalled four misses fill the buffer and the fifth must wait
        @(posedge clk);
        #1;
        mem_ready = 1'b0;
        for (int i = 0; i < 5; i++) begin
            rng = xorshift32(rng);
            a   = make_addr(23'h055550, rng[4:0], rng[6:5], rng[8:7]);
            start_req(store_op_pkg::STORE, a, xorshift32(rng),
                      store_op_pkg::mem_op_width_t'(rng[10:9]));
            if (i < 4) finish_req();
        end
        repeat (10) begin
            @(negedge clk);
            compare_value("done_o", 0, done);
        end
        @(posedge clk);
        #1;
        mem_ready = 1'b1;
        finish_req();
        drain_writes();

        // random mix with memory ready forced high whenever the buffer is full
        for (int i = 0; i < 200; i++) begin
            rng = xorshift32(rng);
            r   = rng;
            @(posedge clk);
            #1;
            mem_ready = r[8] | r[9] | (exp_q.size() >= `WBUF_DEPTH);
            rng = xorshift32(rng);
            start_req(store_op_pkg::req_kind_t'(r[11:10]), rand_addr(r), rng,
                      store_op_pkg::mem_op_width_t'(r[13:12]));
            finish_req();
        end
        @(posedge clk);
        #1;
        req       = 1'b0;
        mem_ready = 1'b1;
        drain_writes();

        report_counts();
        if (value_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset is seen low on RESET_CYCLES rising edges, then released after the edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* design/store_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module store_cache_top (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             req_i,
    input  store_op_pkg::req_kind_t          req_kind_i,
    input  cache_addr_pkg::data_cache_addr_t req_addr_i,
    input  logic [`PORT_WIDTH-1:0]           req_data_i,
    input  store_op_pkg::mem_op_width_t      req_width_i,
    output logic                             done_o,
    output logic                             idle_o,
    output logic                             probe_hit_o,
    output logic [`PORT_WIDTH-1:0]           probe_data_o,
    output logic                             probe_dirty_o,
    input  logic                             mem_ready_i,
    output logic                             mem_write_o,
    output logic [31:0]                      mem_addr_o,
    output logic [`PORT_WIDTH-1:0]           mem_data_o,
    output logic [`PORT_BYTES-1:0]           mem_strb_o
);

    cache_port_if cache_port ();

    cache_addr_pkg::bank_line_t bank_lines [`NUM_BANKS];
    logic                       hit;
    logic [`PORT_WIDTH-1:0]     line_data;
    logic                       line_dirty;
    logic                       wbuf_push;
    store_op_pkg::wbuf_entry_t  wbuf_entry;
    logic                       wbuf_full;

    store_cache_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req_i),
        .req_kind_i    (req_kind_i),
        .req_addr_i    (req_addr_i),
        .req_data_i    (req_data_i),
        .req_width_i   (req_width_i),
        .hit_i         (hit),
        .line_data_i   (line_data),
        .line_dirty_i  (line_dirty),
        .wbuf_full_i   (wbuf_full),
        .port          (cache_port.ctrl),
        .wbuf_push_o   (wbuf_push),
        .wbuf_entry_o  (wbuf_entry),
        .done_o        (done_o),
        .idle_o        (idle_o),
        .probe_hit_o   (probe_hit_o),
        .probe_data_o  (probe_data_o),
        .probe_dirty_o (probe_dirty_o)
    );

    // bank b answers for chip_sel == b
    for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
        cache_bank #(
            .BANK_ID (b)
        ) u_bank (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .port    (cache_port.bank),
            .line_o  (bank_lines[b])
        );
    end

    bank_hit_merge u_merge (
        .lines_i (bank_lines),
        .port    (cache_port.merge),
        .hit_o   (hit),
        .data_o  (line_data),
        .dirty_o (line_dirty)
    );

    store_write_buffer u_wbuf (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (wbuf_push),
        .entry_i     (wbuf_entry),
        .full_o      (wbuf_full),
        .mem_ready_i (mem_ready_i),
        .mem_write_o (mem_write_o),
        .mem_addr_o  (mem_addr_o),
        .mem_data_o  (mem_data_o),
        .mem_strb_o  (mem_strb_o)
    );

endmodule

`default_nettype wire

/* design/store_write_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module store_write_buffer (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      push_i,
    input  store_op_pkg::wbuf_entry_t entry_i,
    output logic                      full_o,
    input  logic                      mem_ready_i,
    output logic                      mem_write_o,
    output logic [31:0]               mem_addr_o,
    output logic [`PORT_WIDTH-1:0]    mem_data_o,
    output logic [`PORT_BYTES-1:0]    mem_strb_o
);

    localparam int PTR_BITS = $clog2(`WBUF_DEPTH);

    store_op_pkg::wbuf_entry_t fifo_mem [`WBUF_DEPTH];
    logic [PTR_BITS-1:0]       wr_ptr;
    logic [PTR_BITS-1:0]       rd_ptr;
    logic [PTR_BITS:0]         count;
    logic                      pop;

    assign full_o = (count == `WBUF_DEPTH);
    assign pop    = mem_ready_i && (count != '0);

    // head goes straight out, one transfer per ready cycle
    assign mem_write_o = pop;
    assign mem_addr_o  = fifo_mem[rd_ptr].addr;
    assign mem_data_o  = fifo_mem[rd_ptr].data;
    assign mem_strb_o  = fifo_mem[rd_ptr].strb;

    always_ff @(posedge clk_i) begin
        if (push_i) fifo_mem[wr_ptr] <= entry_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= (wr_ptr == PTR_BITS'(`WBUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PTR_BITS'(`WBUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_in_range: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        count <= `WBUF_DEPTH
    );

endmodule

`default_nettype wire

/* design/bank_hit_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module bank_hit_merge (
    input  cache_addr_pkg::bank_line_t lines_i [`NUM_BANKS],
    cache_port_if.merge                port,
    output logic                       hit_o,
    output logic [`PORT_WIDTH-1:0]     data_o,
    output logic                       dirty_o
);

    cache_addr_pkg::bank_line_t sel_line;

    // chip_sel names the only bank that can hold this address
    assign sel_line = lines_i[port.address.chip_sel];

    assign hit_o   = sel_line.valid && (sel_line.tag == port.address.tag);
    assign data_o  = sel_line.data;
    assign dirty_o = sel_line.dirty;

endmodule

`default_nettype wire

/* design/cache_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_bank #(
    parameter int BANK_ID = 0
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    cache_port_if.bank                 port,
    output cache_addr_pkg::bank_line_t line_o
);

    localparam int ENTRIES = 1 << `INDEX_BITS;

    logic [`TAG_BITS-1:0]   tag_mem  [ENTRIES];
    logic [`PORT_WIDTH-1:0] data_mem [ENTRIES];
    logic [ENTRIES-1:0]     valid_q;
    logic [ENTRIES-1:0]     dirty_q;
    logic [`INDEX_BITS-1:0] idx;
    logic                   wr_en;

    assign idx   = port.address.index;
    assign wr_en = port.write_cache &&
                   (port.address.chip_sel == BANK_ID[`CHIP_SEL_BITS-1:0]);

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            if (port.access_tag) tag_mem[idx] <= port.address.tag;
            if (port.access_data) begin
                for (int b = 0; b < `PORT_BYTES; b++) begin
                    if (port.byte_write[b]) data_mem[idx][8*b +: 8] <= port.data[8*b +: 8];
                end
            end
        end
        // all banks read together, the merge block picks one
        if (port.read_cache) begin
            line_o <= {tag_mem[idx], valid_q[idx], dirty_q[idx], data_mem[idx]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            if (port.access_valid) valid_q[idx] <= port.valid;
            if (port.access_dirty) dirty_q[idx] <= port.dirty;
        end
    end

    a_no_read_during_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(port.read_cache && port.write_cache)
    );

endmodule

`default_nettype wire

/* design/store_cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module store_cache_ctrl (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             req_i,
    input  store_op_pkg::req_kind_t          req_kind_i,
    input  cache_addr_pkg::data_cache_addr_t req_addr_i,
    input  logic [`PORT_WIDTH-1:0]           req_data_i,
    input  store_op_pkg::mem_op_width_t      req_width_i,
    input  logic                             hit_i,
    input  logic [`PORT_WIDTH-1:0]           line_data_i,
    input  logic                             line_dirty_i,
    input  logic                             wbuf_full_i,
    cache_port_if.ctrl                       port,
    output logic                             wbuf_push_o,
    output store_op_pkg::wbuf_entry_t        wbuf_entry_o,
    output logic                             done_o,
    output logic                             idle_o,
    output logic                             probe_hit_o,
    output logic [`PORT_WIDTH-1:0]           probe_data_o,
    output logic                             probe_dirty_o
);

    typedef enum logic [2:0] {
        IDLE,
        COMPARE_TAG,
        WRITE_DATA,
        MEMORY_WRITE,
        INVALIDATE,
        FILL_WRITE
    } ctrl_state_t;

    ctrl_state_t            state_q;
    ctrl_state_t            state_d;
    logic [`PORT_WIDTH-1:0] aligned_data;
    logic [`PORT_BYTES-1:0] aligned_strb;
    logic                   probe_done;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign idle_o = (state_q == IDLE);

    // place the store bytes on their lanes, shared by cache and buffer
    always_comb begin
        aligned_data = '0;
        aligned_strb = '0;
        case (req_width_i)
            store_op_pkg::BYTE: begin
                aligned_strb[req_addr_i.byte_sel] = 1'b1;
                aligned_data[8*req_addr_i.byte_sel +: 8] = req_data_i[7:0];
            end
            store_op_pkg::HALF_WORD: begin
                // byte_sel[0] is ignored, half words sit on an even lane pair
                if (req_addr_i.byte_sel[1]) begin
                    aligned_strb[`PORT_BYTES-1 -: `PORT_BYTES/2] = '1;
                    aligned_data[`PORT_WIDTH-1 -: `PORT_WIDTH/2] =
                        req_data_i[`PORT_WIDTH/2-1:0];
                end else begin
                    aligned_strb[`PORT_BYTES/2-1:0] = '1;
                    aligned_data[`PORT_WIDTH/2-1:0] = req_data_i[`PORT_WIDTH/2-1:0];
                end
            end
            default: begin
                aligned_strb = '1;
                aligned_data = req_data_i;
            end
        endcase
    end

    always_comb begin
        wbuf_entry_o.addr = req_addr_i;
        wbuf_entry_o.addr[`BYTE_SEL_BITS-1:0] = '0;
        wbuf_entry_o.data = aligned_data;
        wbuf_entry_o.strb = aligned_strb;
    end

    always_comb begin
        state_d           = state_q;
        done_o            = 1'b0;
        probe_done        = 1'b0;
        wbuf_push_o       = 1'b0;
        port.read_cache   = 1'b0;
        port.write_cache  = 1'b0;
        port.address      = '0;
        port.byte_write   = '0;
        port.data         = '0;
        port.dirty        = 1'b0;
        port.valid        = 1'b0;
        port.access_data  = 1'b0;
        port.access_tag   = 1'b0;
        port.access_valid = 1'b0;
        port.access_dirty = 1'b0;

        case (state_q)
            IDLE: begin
                if (req_i) begin
                    if (req_kind_i == store_op_pkg::FILL) begin
                        state_d = FILL_WRITE;
                    end else begin
                        // every bank latches this index, the tag follows next cycle
                        port.read_cache       = 1'b1;
                        port.address.index    = req_addr_i.index;
                        port.address.chip_sel = req_addr_i.chip_sel;
                        state_d               = COMPARE_TAG;
                    end
                end
            end

            COMPARE_TAG: begin
                port.address = req_addr_i;
                case (req_kind_i)
                    store_op_pkg::STORE: begin
                        state_d = hit_i ? WRITE_DATA : MEMORY_WRITE;
                    end
                    store_op_pkg::INVALIDATE: begin
                        if (hit_i) begin
                            state_d = INVALIDATE;
                        end else begin
                            // nothing cached, nothing to clear
                            done_o  = 1'b1;
                            state_d = IDLE;
                        end
                    end
                    default: begin
                        probe_done = 1'b1;
                        done_o     = 1'b1;
                        state_d    = IDLE;
                    end
                endcase
            end

            WRITE_DATA: begin
                port.write_cache  = 1'b1;
                port.address      = req_addr_i;
                port.byte_write   = aligned_strb;
                port.data         = aligned_data;
                port.dirty        = 1'b1;
                port.access_data  = 1'b1;
                port.access_dirty = 1'b1;
                done_o            = 1'b1;
                state_d           = IDLE;
            end

            MEMORY_WRITE: begin
                // write-no-allocate, hold here until the buffer has room
                if (!wbuf_full_i) begin
                    wbuf_push_o = 1'b1;
                    done_o      = 1'b1;
                    state_d     = IDLE;
                end
            end

            INVALIDATE: begin
                port.write_cache  = 1'b1;
                port.address      = req_addr_i;
                port.access_valid = 1'b1;
                done_o            = 1'b1;
                state_d           = IDLE;
            end

            FILL_WRITE: begin
                port.write_cache  = 1'b1;
                port.address      = req_addr_i;
                port.byte_write   = '1;
                port.data         = req_data_i;
                port.valid        = 1'b1;
                port.access_data  = 1'b1;
                port.access_tag   = 1'b1;
                port.access_valid = 1'b1;
                port.access_dirty = 1'b1;
                done_o            = 1'b1;
                state_d           = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // probe results only mean something in the done cycle
    assign probe_hit_o   = probe_done & hit_i;
    assign probe_dirty_o = probe_done & line_dirty_i;
    assign probe_data_o  = probe_done ? line_data_i : '0;

    a_write_xor_push: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(port.write_cache && wbuf_push_o)
    );

    // the buffer drops nothing, so a push must see room
    a_no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        wbuf_push_o |-> !wbuf_full_i
    );

endmodule

`default_nettype wire

/* design/cache_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

interface cache_port_if;

    logic                             read_cache;
    logic                             write_cache;
    cache_addr_pkg::data_cache_addr_t address;
    logic [`PORT_BYTES-1:0]           byte_write;
    logic [`PORT_WIDTH-1:0]           data;
    logic                             dirty;
    logic                             valid;

    // field enables for a write
    logic                             access_data;
    logic                             access_tag;
    logic                             access_valid;
    logic                             access_dirty;

    modport ctrl (
        output read_cache, write_cache, address, byte_write, data, dirty, valid,
        output access_data, access_tag, access_valid, access_dirty
    );

    modport bank (
        input read_cache, write_cache, address, byte_write, data, dirty, valid,
        input access_data, access_tag, access_valid, access_dirty
    );

    modport merge (
        input address
    );

endinterface

`default_nettype wire

/* design/store_op_pkg.sv */
`default_nettype none

`include "cache_params.svh"

package store_op_pkg;

    // DOUBLE_WORD is accepted but stored as a full word
    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD,
        DOUBLE_WORD
    } mem_op_width_t;

    typedef enum logic [1:0] {
        STORE,
        INVALIDATE,
        FILL,
        PROBE
    } req_kind_t;

    // one buffered memory write, address is word aligned
    typedef struct packed {
        logic [31:0]            addr;
        logic [`PORT_WIDTH-1:0] data;
        logic [`PORT_BYTES-1:0] strb;
    } wbuf_entry_t;

endpackage

`default_nettype wire

/* design/cache_addr_pkg.sv */
`default_nettype none

`include "cache_params.svh"

package cache_addr_pkg;

    // byte address as the cache sees it, tag in the upper bits
    typedef struct packed {
        logic [`TAG_BITS-1:0]      tag;
        logic [`INDEX_BITS-1:0]    index;
        logic [`CHIP_SEL_BITS-1:0] chip_sel;
        logic [`BYTE_SEL_BITS-1:0] byte_sel;
    } data_cache_addr_t;

    // registered read result of one bank
    typedef struct packed {
        logic [`TAG_BITS-1:0]   tag;
        logic                   valid;
        logic                   dirty;
        logic [`PORT_WIDTH-1:0] data;
    } bank_line_t;

endpackage

`default_nettype wire

/* include/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// data port
`define PORT_WIDTH 32
`define PORT_BYTES 4

// address fields, from the low end of a 32-bit byte address
`define BYTE_SEL_BITS 2
`define CHIP_SEL_BITS 2
`define INDEX_BITS 5
`define TAG_BITS 23

// one bank per chip select value
`define NUM_BANKS 4

// store misses waiting for memory
`define WBUF_DEPTH 4

`endif
